/* fetchPkg.sv */
/*
   Shared definitions for the instruction fetch stage.
   Instructions are 16 bits: opcode in [15:11], source A in [10:8],
   source B in [7:5]. Addresses are byte addresses, the PC steps by 2.
*/
package fetchPkg;

   // datapath widths
   localparam int addrW = 16;
   localparam int instrW = 16;
   localparam int regW = 3;

   // instruction field positions
   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int srcAMsb = 10;
   localparam int srcALsb = 8;
   localparam int srcBMsb = 7;
   localparam int srcBLsb = 5;

   typedef enum logic [4:0] {
      opHalt = 5'd0,
      opNop = 5'd1,
      opAddi,
      opLd,
      opSt,
      opAlu,
      opBeqz,
      opJ
   } opcodeE;

   // write-back source of an instruction in flight
   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbPc
   } wbSelE;

   // operand forwarding select, named after the stage that supplies it
   typedef enum logic [1:0] {
      fwdNone,
      fwdX,
      fwdM,
      fwdW
   } fwdSelE;

   // bubble pushed into decode
   localparam logic [instrW-1:0] nopInstr = 16'h0800;

   function automatic opcodeE opcodeOf(input logic [instrW-1:0] instr);
      return opcodeE'(instr[opMsb:opLsb]);
   endfunction

   function automatic logic [regW-1:0] srcAOf(input logic [instrW-1:0] instr);
      return instr[srcAMsb:srcALsb];
   endfunction

   function automatic logic [regW-1:0] srcBOf(input logic [instrW-1:0] instr);
      return instr[srcBMsb:srcBLsb];
   endfunction

endpackage

/* instrMem.sv */
/*
   Word-addressed instruction memory, memWords deep, power of two.
   Addresses above memWords alias. The array has no reset, so the
   program goes in through the load port before fetch starts.
   A refill is answered exactly memLatency (>= 1) cycles after memRd,
   with one request in flight at a time.
*/
`timescale 1ns/1ps

module instrMem #(
   parameter int memWords = 256,
   parameter int memLatency = 3
) (
   input logic clk,
   input logic loadEn,
   input logic [fetchPkg::addrW-1:0] loadAddr,
   input logic [fetchPkg::instrW-1:0] loadData,
   input logic memRd,
   input logic [fetchPkg::addrW-1:0] memAddr,
   output logic memValid,
   output logic [fetchPkg::instrW-1:0] memData
);
   import fetchPkg::*;

   localparam int memAW = $clog2(memWords);

   logic [instrW-1:0] mem [memWords];
   logic [memLatency-1:0] reqValid;
   logic [memAW-1:0] reqAddr [memLatency];

   // program load, one word per cycle
   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr[memAW-1:0]] <= loadData;
      end
   end

   // latency line, the request walks one stage per cycle
   always_ff @(posedge clk) begin
      reqValid[0] <= memRd;
      reqAddr[0] <= memAddr[memAW-1:0];
      for (int i = 1; i < memLatency; i++) begin
         reqValid[i] <= reqValid[i-1];
         reqAddr[i] <= reqAddr[i-1];
      end
   end

   // word is read as the request leaves the last stage
   assign memValid = reqValid[memLatency-1];
   assign memData = mem[reqAddr[memLatency-1]];

   // the cache must wait for its answer before asking again
   aSingleRequest: assert property (@(posedge clk) memRd |-> !(|reqValid))
      else $error("instrMem: memRd while a request is in flight");

endmodule

/* instrCache.sv */
/*
   Direct-mapped instruction cache, one word per line.
   cacheLines and memWords are powers of two, memWords > cacheLines.
   Lookup is combinational; stall is high while a refill is pending.
   A started refill always completes into its line, even after the PC moves.
*/
`timescale 1ns/1ps

module instrCache #(
   parameter int cacheLines = 16,
   parameter int memWords = 256
) (
   input logic clk,
   input logic rstN,
   input logic [fetchPkg::addrW-1:0] pc,
   output logic [fetchPkg::instrW-1:0] cacheInstr,
   output logic cacheHit,
   output logic stall,
   output logic memRd,
   output logic [fetchPkg::addrW-1:0] memAddr,
   input logic memValid,
   input logic [fetchPkg::instrW-1:0] memData
);
   import fetchPkg::*;

   localparam int idxW = $clog2(cacheLines);
   localparam int memAW = $clog2(memWords);
   localparam int tagW = memAW - idxW;

   typedef enum logic {
      stIdle,
      stRefill
   } stateE;

   stateE state;

   logic [cacheLines-1:0] lineValid;
   logic [tagW-1:0] lineTag [cacheLines];
   logic [instrW-1:0] lineData [cacheLines];

   logic [addrW-2:0] wordAddr;
   logic [idxW-1:0] idx;
   logic [tagW-1:0] tag;
   logic [idxW-1:0] refillIdx;
   logic [tagW-1:0] refillTag;
   logic startRefill;

   // byte bit of the PC is dropped
   assign wordAddr = pc[addrW-1:1];
   assign idx = wordAddr[idxW-1:0];
   assign tag = wordAddr[memAW-1:idxW];

   assign cacheHit = lineValid[idx] && (lineTag[idx] == tag);
   assign cacheInstr = lineData[idx];
   assign stall = (state == stRefill);

   assign startRefill = (state == stIdle) && !cacheHit;

   // miss FSM and valid bits
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
         memRd <= 1'b0;
         lineValid <= '0;
      end else begin
         memRd <= 1'b0;
         case (state)
            stIdle: begin
               if (!cacheHit) begin
                  state <= stRefill;
                  memRd <= 1'b1;
               end
            end
            stRefill: begin
               if (memValid) begin
                  state <= stIdle;
                  lineValid[refillIdx] <= 1'b1;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // refill target is captured at the miss, line written on return
   always_ff @(posedge clk) begin
      if (startRefill) begin
         refillIdx <= idx;
         refillTag <= tag;
         memAddr <= {1'b0, wordAddr};
      end
      if (stall && memValid) begin
         lineTag[refillIdx] <= refillTag;
         lineData[refillIdx] <= memData;
      end
   end

   // a new request is only launched from idle
   aRdFromIdle: assert property (@(posedge clk) disable iff (!rstN)
      $rose(memRd) |-> $past(state == stIdle))
      else $error("instrCache: memRd raised during refill");

   // memory answers only what was asked
   aValidInRefill: assert property (@(posedge clk) disable iff (!rstN)
      memValid |-> (state == stRefill))
      else $error("instrCache: memValid outside refill");

endmodule

/* hazardUnit.sv */
/*
   Fetch/decode register with load-use detection and forwarding selects.
   pcHold is combinational and lasts one cycle per hazard; the D/X/M write
   information must describe the instructions ahead of the one being fetched.
   Bubbles are nopInstr with instrValid low.
*/
`timescale 1ns/1ps

module hazardUnit (
   input logic clk,
   input logic rstN,
   input logic [fetchPkg::instrW-1:0] fetchInstr,
   input logic [fetchPkg::addrW-1:0] fetchPc,
   input logic fetchValid,
   input logic flush,
   input logic regWrtD,
   input logic regWrtX,
   input logic regWrtM,
   input logic [fetchPkg::regW-1:0] wrtRegD,
   input logic [fetchPkg::regW-1:0] wrtRegX,
   input logic [fetchPkg::regW-1:0] wrtRegM,
   input fetchPkg::wbSelE wbDataSelD,
   output logic pcHold,
   output logic [fetchPkg::instrW-1:0] instruction,
   output logic [fetchPkg::addrW-1:0] incPC,
   output logic instrValid,
   output fetchPkg::fwdSelE fwCntrlA,
   output fetchPkg::fwdSelE fwCntrlB
);
   import fetchPkg::*;

   opcodeE opcode;
   logic [regW-1:0] srcA;
   logic [regW-1:0] srcB;
   logic useA;
   logic useB;
   logic loadUse;
   logic takeInstr;
   fwdSelE fwdA;
   fwdSelE fwdB;

   // producer in D is in X when this one reaches decode, and so on
   function automatic fwdSelE nearestFwd(input logic [regW-1:0] src, input logic used);
      fwdSelE sel;
      sel = fwdNone;
      if (used) begin
         if (regWrtD && (wrtRegD == src)) begin
            sel = fwdX;
         end else if (regWrtX && (wrtRegX == src)) begin
            sel = fwdM;
         end else if (regWrtM && (wrtRegM == src)) begin
            sel = fwdW;
         end
      end
      return sel;
   endfunction

   assign opcode = opcodeOf(fetchInstr);
   assign srcA = srcAOf(fetchInstr);
   assign srcB = srcBOf(fetchInstr);

   // which register fields the opcode reads
   always_comb begin
      case (opcode)
         opAlu, opSt: begin
            useA = 1'b1;
            useB = 1'b1;
         end
         opNop, opHalt, opJ: begin
            useA = 1'b0;
            useB = 1'b0;
         end
         default: begin
            useA = 1'b1;
            useB = 1'b0;
         end
      endcase
   end

   // forwarding select per operand
   always_comb begin
      fwdA = nearestFwd(srcA, useA);
      fwdB = nearestFwd(srcB, useB);
   end

   // load in D cannot forward in time
   assign loadUse = fetchValid && regWrtD && (wbDataSelD == wbMem)
      && ((useA && (wrtRegD == srcA)) || (useB && (wrtRegD == srcB)));
   assign pcHold = loadUse;

   assign takeInstr = fetchValid && !flush && !loadUse;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         instruction <= nopInstr;
         instrValid <= 1'b0;
         fwCntrlA <= fwdNone;
         fwCntrlB <= fwdNone;
      end else if (takeInstr) begin
         instruction <= fetchInstr;
         instrValid <= 1'b1;
         fwCntrlA <= fwdA;
         fwCntrlB <= fwdB;
      end else begin
         instruction <= nopInstr;
         instrValid <= 1'b0;
         fwCntrlA <= fwdNone;
         fwCntrlB <= fwdNone;
      end
   end

   // incPC tracks the word taken into decode
   always_ff @(posedge clk) begin
      if (takeInstr) begin
         incPC <= fetchPc + addrW'(2);
      end
   end

   aValidNotNop: assert property (@(posedge clk) disable iff (!rstN)
      instrValid |-> (instruction != nopInstr))
      else $error("hazardUnit: valid instruction equals the bubble");

endmodule

/* fetchStage.sv */
/*
   Instruction fetch stage: PC, instruction cache, backing memory and
   the fetch/decode register. Load the program while rstN is low; loads
   do not invalidate cached lines. An odd redirect target is refused and
   raises err until the next even redirect.
*/
`timescale 1ns/1ps

module fetchStage #(
   parameter int cacheLines = 16,
   parameter int memWords = 256,
   parameter int memLatency = 3
) (
   input logic clk,
   input logic rstN,
   input logic [fetchPkg::addrW-1:0] newPC,
   input logic jumpInstX,
   input logic branchMispredict,
   input logic createDump,
   input logic regWrtD,
   input logic regWrtX,
   input logic regWrtM,
   input logic [fetchPkg::regW-1:0] wrtRegD,
   input logic [fetchPkg::regW-1:0] wrtRegX,
   input logic [fetchPkg::regW-1:0] wrtRegM,
   input fetchPkg::wbSelE wbDataSelD,
   input logic loadEn,
   input logic [fetchPkg::addrW-1:0] loadAddr,
   input logic [fetchPkg::instrW-1:0] loadData,
   output logic [fetchPkg::instrW-1:0] instruction,
   output logic [fetchPkg::addrW-1:0] incPC,
   output logic instrValid,
   output fetchPkg::fwdSelE fwCntrlA,
   output fetchPkg::fwdSelE fwCntrlB,
   output logic err
);
   import fetchPkg::*;

   logic [addrW-1:0] pc;
   logic [addrW-1:0] pcInc;
   logic [addrW-1:0] pcNext;
   logic [instrW-1:0] cacheInstr;
   logic cacheHit;
   logic stall;
   logic memRd;
   logic [addrW-1:0] memAddr;
   logic memValid;
   logic [instrW-1:0] memData;
   logic pcHold;
   logic redirect;
   logic badTarget;
   logic fetchValid;

   assign redirect = jumpInstX | branchMispredict;
   assign badTarget = redirect & newPC[0];
   assign pcInc = pc + addrW'(2);

   // redirect (good or bad), halt and refill all keep the word out of decode
   assign fetchValid = cacheHit & ~stall & ~redirect & ~badTarget & ~createDump;

   always_comb begin
      if (redirect) begin
         pcNext = badTarget ? pc : newPC;
      end else if (fetchValid && !pcHold) begin
         pcNext = pcInc;
      end else begin
         pcNext = pc;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
         err <= 1'b0;
      end else begin
         pc <= pcNext;
         // sticky until an even redirect
         if (redirect) begin
            err <= badTarget;
         end
      end
   end

   instrCache #(
      .cacheLines(cacheLines),
      .memWords(memWords)
   ) i_instrCache (
      .clk(clk),
      .rstN(rstN),
      .pc(pc),
      .cacheInstr(cacheInstr),
      .cacheHit(cacheHit),
      .stall(stall),
      .memRd(memRd),
      .memAddr(memAddr),
      .memValid(memValid),
      .memData(memData)
   );

   instrMem #(
      .memWords(memWords),
      .memLatency(memLatency)
   ) i_instrMem (
      .clk(clk),
      .loadEn(loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .memRd(memRd),
      .memAddr(memAddr),
      .memValid(memValid),
      .memData(memData)
   );

   hazardUnit i_hazardUnit (
      .clk(clk),
      .rstN(rstN),
      .fetchInstr(cacheInstr),
      .fetchPc(pc),
      .fetchValid(fetchValid),
      .flush(redirect),
      .regWrtD(regWrtD),
      .regWrtX(regWrtX),
      .regWrtM(regWrtM),
      .wrtRegD(wrtRegD),
      .wrtRegX(wrtRegX),
      .wrtRegM(wrtRegM),
      .wbDataSelD(wbDataSelD),
      .pcHold(pcHold),
      .instruction(instruction),
      .incPC(incPC),
      .instrValid(instrValid),
      .fwCntrlA(fwCntrlA),
      .fwCntrlB(fwCntrlB)
   );

   aPcEven: assert property (@(posedge clk) disable iff (!rstN) !pc[0])
      else $error("fetchStage: odd PC");

endmodule

/* tbFetch.sv */
/*
   Testbench for the fetch stage with a random program and random later-stage
   traffic from a fixed seed. The model tracks the PC and which cache lines are
   known to hold their word; a missing instruction is only an error once the
   line is known and no refill can still be pending.
*/
`timescale 1ns/1ps

module tbFetch;
   import fetchPkg::*;

   localparam int cacheLines = 16;
   localparam int memWords = 256;
   localparam int memLatency = 3;
   localparam int passLen = cacheLines - 1;
   localparam int redirCycles = 150;
   localparam int fwdCycles = 300;
   localparam int oddCycles = 120;
   localparam int dumpCycles = 120;
   localparam int stimCycles = memWords + 2 * passLen * (memLatency + 4)
      + redirCycles + fwdCycles + oddCycles + dumpCycles;
   localparam int cycleLimit = 4 * stimCycles + 256 * memLatency;

   logic clk;
   logic rstN;
   logic [addrW-1:0] newPC;
   logic jumpInstX;
   logic branchMispredict;
   logic createDump;
   logic regWrtD;
   logic regWrtX;
   logic regWrtM;
   logic [regW-1:0] wrtRegD;
   logic [regW-1:0] wrtRegX;
   logic [regW-1:0] wrtRegM;
   wbSelE wbDataSelD;
   logic loadEn;
   logic [addrW-1:0] loadAddr;
   logic [instrW-1:0] loadData;
   logic [instrW-1:0] instruction;
   logic [addrW-1:0] incPC;
   logic instrValid;
   fwdSelE fwCntrlA;
   fwdSelE fwCntrlB;
   logic err;

   // reference state
   logic [instrW-1:0] progWords [memWords];
   bit lineKnown [cacheLines];
   int lineWord [cacheLines];
   logic [addrW-1:0] expPc;
   logic expErr;
   int quiet;
   int cycleCount = 0;
   int errorCount = 0;
   int checkCount = 0;
   int testCount = 0;
   int testErrors;
   int delivered;
   int hazards;
   string testName;

   fetchStage #(
      .cacheLines(cacheLines),
      .memWords(memWords),
      .memLatency(memLatency)
   ) i_fetchStage (
      .clk(clk),
      .rstN(rstN),
      .newPC(newPC),
      .jumpInstX(jumpInstX),
      .branchMispredict(branchMispredict),
      .createDump(createDump),
      .regWrtD(regWrtD),
      .regWrtX(regWrtX),
      .regWrtM(regWrtM),
      .wrtRegD(wrtRegD),
      .wrtRegX(wrtRegX),
      .wrtRegM(wrtRegM),
      .wbDataSelD(wbDataSelD),
      .loadEn(loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .instruction(instruction),
      .incPC(incPC),
      .instrValid(instrValid),
      .fwCntrlA(fwCntrlA),
      .fwCntrlB(fwCntrlB),
      .err(err)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   initial begin
      wait (cycleCount >= cycleLimit);
      $display("timeout: run stopped after %0d cycles", cycleCount);
      $display("*** FAILED ***");
      $finish;
   end

   function automatic int wordOf(input logic [addrW-1:0] a);
      return int'(a[addrW-1:1]) % memWords;
   endfunction

   function automatic bit knownHit(input logic [addrW-1:0] a);
      int w;
      w = wordOf(a);
      return lineKnown[w % cacheLines] && (lineWord[w % cacheLines] == w);
   endfunction

   // register fields read by each opcode
   task automatic operandUse(input logic [instrW-1:0] instr, output bit useA, output bit useB);
      opcodeE op;
      op = opcodeE'(instr[15:11]);
      useA = !(op inside {opNop, opHalt, opJ});
      useB = (op inside {opAlu, opSt});
   endtask

   // nearest producer wins since the D-stage writer is in X by decode time
   function automatic fwdSelE expectFwd(input logic [regW-1:0] src, input bit used);
      if (!used) begin
         return fwdNone;
      end
      if (regWrtD && (wrtRegD == src)) begin
         return fwdX;
      end
      if (regWrtX && (wrtRegX == src)) begin
         return fwdM;
      end
      if (regWrtM && (wrtRegM == src)) begin
         return fwdW;
      end
      return fwdNone;
   endfunction

   task automatic checkWord(input string what, input logic [15:0] exp, input logic [15:0] act);
      checkCount++;
      if (act !== exp) begin
         errorCount++;
         testErrors++;
         $display("error %s: %s expected %h actual %h", testName, what, exp, act);
      end
   endtask

   task automatic checkFwd(input string what, input fwdSelE exp, input fwdSelE act);
      checkCount++;
      if (act !== exp) begin
         errorCount++;
         testErrors++;
         $display("error %s: %s expected %s actual %s", testName, what, exp.name(), act.name());
      end
   endtask

   task automatic checkFlag(input string what, input logic exp, input logic act);
      checkCount++;
      if (act !== exp) begin
         errorCount++;
         testErrors++;
         $display("error %s: %s expected %b actual %b", testName, what, exp, act);
      end
   endtask

   task automatic reportFault(input string msg);
      errorCount++;
      testErrors++;
      $display("%s: %s at PC %h", testName, msg, expPc);
   endtask

   // advance one clock and compare while the fetch-cycle inputs still stand
   task automatic step();
      logic [instrW-1:0] instr;
      bit useA;
      bit useB;
      bit loadUse;
      bit hit;
      bit sure;
      int w;
      @(posedge clk);
      #1;
      if (rstN) begin
         w = wordOf(expPc);
         hit = knownHit(expPc);
         sure = hit && (quiet >= memLatency + 2);
         if (hit) begin
            quiet++;
         end else begin
            // a refill may start here and replace the line
            quiet = 0;
            lineKnown[w % cacheLines] = 1'b0;
         end
         instr = progWords[w];
         operandUse(instr, useA, useB);
         loadUse = regWrtD && (wbDataSelD == wbMem)
            && ((useA && (wrtRegD == instr[10:8])) || (useB && (wrtRegD == instr[7:5])));
         if (jumpInstX || branchMispredict) begin
            checkFlag("instrValid after redirect", 1'b0, instrValid);
            expErr = newPC[0];
            if (!newPC[0]) begin
               expPc = newPC;
            end
         end else if (createDump) begin
            checkFlag("instrValid during halt", 1'b0, instrValid);
         end else if (instrValid) begin
            if (loadUse) begin
               reportFault("instruction entered decode over a load-use hazard");
            end
            checkWord("instruction", instr, instruction);
            checkWord("incPC", expPc + 16'd2, incPC);
            checkFwd("fwCntrlA", expectFwd(instr[10:8], useA), fwCntrlA);
            checkFwd("fwCntrlB", expectFwd(instr[7:5], useB), fwCntrlB);
            delivered++;
            lineKnown[w % cacheLines] = 1'b1;
            lineWord[w % cacheLines] = w;
            expPc = expPc + 16'd2;
         end else if (sure) begin
            if (loadUse) begin
               hazards++;
            end else begin
               reportFault("cached instruction did not enter decode");
            end
         end
         checkFlag("err", expErr, err);
      end
   endtask

   task automatic idleInputs();
      newPC = '0;
      jumpInstX = 1'b0;
      branchMispredict = 1'b0;
      createDump = 1'b0;
      regWrtD = 1'b0;
      regWrtX = 1'b0;
      regWrtM = 1'b0;
      wrtRegD = '0;
      wrtRegX = '0;
      wrtRegM = '0;
      wbDataSelD = wbAlu;
   endtask

   task automatic randomWrites();
      regWrtD = 1'($urandom_range(1));
      regWrtX = 1'($urandom_range(1));
      regWrtM = 1'($urandom_range(1));
      wrtRegD = 3'($urandom_range(7));
      wrtRegX = 3'($urandom_range(7));
      wrtRegM = 3'($urandom_range(7));
      // loads on half the cycles to provoke load-use
      case ($urandom_range(3))
         0, 1: wbDataSelD = wbMem;
         2: wbDataSelD = wbAlu;
         default: wbDataSelD = wbPc;
      endcase
   endtask

   task automatic randomRedirect(input int oneIn, input bit allowOdd);
      logic [addrW-1:0] target;
      jumpInstX = 1'b0;
      branchMispredict = 1'b0;
      if ($urandom_range(oneIn - 1) == 0) begin
         target = 16'($urandom_range(2 * memWords - 1));
         if (!allowOdd) begin
            target[0] = 1'b0;
         end
         newPC = target;
         if ($urandom_range(1) == 0) begin
            jumpInstX = 1'b1;
         end else begin
            branchMispredict = 1'b1;
         end
      end
   endtask

   task automatic startTest(input string name);
      testName = name;
      testErrors = 0;
      delivered = 0;
      hazards = 0;
   endtask

   task automatic endTest();
      testCount++;
      $display("test %s finished: %0d instructions, %0d load-use bubbles, %0d errors",
         testName, delivered, hazards, testErrors);
   endtask

   initial begin
      logic [instrW-1:0] word;
      int dumpLeft;
      void'($urandom(32'h2188_975e));
      for (int i = 0; i < memWords; i++) begin
         word = {5'($urandom_range(7)), 11'($urandom())};
         // a valid word may never look like the bubble
         if (word == nopInstr) begin
            word[0] = 1'b1;
         end
         progWords[i] = word;
      end
      for (int i = 0; i < cacheLines; i++) begin
         lineKnown[i] = 1'b0;
         lineWord[i] = 0;
      end
      expPc = '0;
      expErr = 1'b0;
      quiet = 0;
      dumpLeft = 0;

      // first words go in under reset and fetch stays halted until the load ends
      startTest("programLoad");
      idleInputs();
      rstN = 1'b0;
      createDump = 1'b1;
      loadEn = 1'b1;
      loadAddr = '0;
      loadData = progWords[0];
      for (int i = 1; i <= memWords; i++) begin
         step();
         if (i == 4) begin
            rstN = 1'b1;
         end
         if (i < memWords) begin
            loadAddr = 16'(i);
            loadData = progWords[i];
         end else begin
            loadEn = 1'b0;
         end
      end
      endTest();

      startTest("coldSequential");
      createDump = 1'b0;
      while (delivered < passLen) begin
         step();
      end
      endTest();

      startTest("cachedSequential");
      jumpInstX = 1'b1;
      newPC = '0;
      step();
      jumpInstX = 1'b0;
      while (delivered < passLen) begin
         step();
      end
      endTest();

      startTest("redirect");
      for (int i = 0; i < redirCycles; i++) begin
         randomRedirect(8, 1'b0);
         step();
      end
      endTest();

      startTest("forwardLoadUse");
      for (int i = 0; i < fwdCycles; i++) begin
         randomWrites();
         randomRedirect(24, 1'b0);
         step();
      end
      endTest();

      startTest("oddTarget");
      idleInputs();
      for (int i = 0; i < oddCycles; i++) begin
         randomRedirect(6, 1'b1);
         step();
      end
      // an even redirect clears err
      branchMispredict = 1'b0;
      jumpInstX = 1'b1;
      newPC = 16'h0040;
      step();
      jumpInstX = 1'b0;
      step();
      endTest();

      startTest("createDump");
      for (int i = 0; i < dumpCycles; i++) begin
         if ((dumpLeft == 0) && ($urandom_range(9) == 0)) begin
            dumpLeft = int'($urandom_range(8, 1));
         end
         createDump = (dumpLeft > 0);
         if (dumpLeft > 0) begin
            dumpLeft--;
         end
         step();
      end
      createDump = 1'b0;
      for (int i = 0; i < 2 * memLatency + 4; i++) begin
         step();
      end
      endTest();

      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* flist.f */
fetchPkg.sv
instrMem.sv
instrCache.sv
hazardUnit.sv
fetchStage.sv
tbFetch.sv

/* run.sh */
#!/bin/sh
# builds and runs the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module tbFetch \
   --Mdir obj_dir -o simFetch -f flist.f; then
   echo "verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/simFetch); then
   printf '%s\n' "$out"
   echo "simulation ended with an error status"
   exit 1
fi
printf '%s\n' "$out"

# the verdict comes from the testbench report
if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
echo "testbench reported failure"
exit 1
